//--- Makefile
# Verilator build and run of the divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_div_pipeline
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal -j $(JOBS)
PASS_TEXT ?= Regression passed

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG JOBS VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "pass line found in $(LOG)"; \
	else \
		echo "pass line missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
source/div_pkg.sv
source/div_operand_prep.sv
source/div_step_stage.sv
source/div_result_fix.sv
source/div_pipeline_top.sv
testbench/div_checker.sv
testbench/tb_div_pipeline.sv

//--- source/div_operand_prep.sv
`timescale 1ns/1ps

// input stage of the divide pipeline
// the step stages only ever see unsigned magnitudes, so the sign handling
// of DIV and REM is split between this stage and div_result_fix
module div_operand_prep import div_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    valid_i,
  input  div_op_e op_i,
  input  word_t   dividend_i,
  input  word_t   divisor_i,
  output logic    valid_o,
  output word_t   rem_o,
  output word_t   quo_o,
  output word_t   divisor_o,
  output logic    negate_o,
  output logic    want_rem_o
);

  logic  signed_op;
  logic  dividend_neg;
  logic  divisor_neg;
  word_t dividend_mag;
  word_t divisor_mag;
  logic  negate_next;
  logic  want_rem_next;

  assign signed_op = (op_i == DIV_OP_DIV) || (op_i == DIV_OP_REM);

  // sign bits only count for the signed forms
  assign dividend_neg = signed_op && dividend_i[XLEN-1];
  assign divisor_neg  = signed_op && divisor_i[XLEN-1];

  // two's complement magnitude of negative operands
  // the most negative value maps onto itself, which is still its
  // correct unsigned magnitude
  assign dividend_mag = dividend_neg ? (~dividend_i + 1'b1) : dividend_i;
  assign divisor_mag  = divisor_neg ? (~divisor_i + 1'b1) : divisor_i;

  always_comb begin
    negate_next = 1'b0;
    case (op_i)
      // a zero divisor must leave the all-ones quotient untouched
      DIV_OP_DIV: negate_next = (dividend_neg ^ divisor_neg) && (divisor_i != '0);
      // remainder follows the sign of the dividend
      DIV_OP_REM: negate_next = dividend_neg;
      default:    negate_next = 1'b0;
    endcase
  end

  assign want_rem_next = (op_i == DIV_OP_REM) || (op_i == DIV_OP_REMU);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    // partial remainder starts at zero, the dividend sits in the shift register
    rem_o      <= '0;
    quo_o      <= dividend_mag;
    divisor_o  <= divisor_mag;
    negate_o   <= negate_next;
    want_rem_o <= want_rem_next;
  end

endmodule

//--- source/div_pipeline_top.sv
`timescale 1ns/1ps

// fully pipelined 32-bit divide unit for DIV, DIVU, REM and REMU
// one operation may enter per cycle, results leave in issue order
// STAGE_COUNT must divide XLEN evenly: 1, 2, 4, 8, 16 or 32
module div_pipeline_top import div_pkg::*; #(
  parameter int STAGE_COUNT = 8
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    valid_i,
  input  div_op_e op_i,
  input  word_t   dividend_i,
  input  word_t   divisor_i,
  output logic    valid_o,
  output word_t   result_o
);

  // prep, the step stages and the output stage each take one cycle
  localparam int LATENCY = STAGE_COUNT + 2;

  // one link after each register stage except the final output stage
  localparam int LINK_COUNT = LATENCY - 1;

  // link 0 is driven by prep, link k by step stage k-1
  logic  valid_link    [LINK_COUNT];
  word_t rem_link      [LINK_COUNT];
  word_t quo_link      [LINK_COUNT];
  word_t divisor_link  [LINK_COUNT];
  logic  negate_link   [LINK_COUNT];
  logic  want_rem_link [LINK_COUNT];

  div_operand_prep u_prep (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .valid_o    (valid_link[0]),
    .rem_o      (rem_link[0]),
    .quo_o      (quo_link[0]),
    .divisor_o  (divisor_link[0]),
    .negate_o   (negate_link[0]),
    .want_rem_o (want_rem_link[0])
  );

  for (genvar s = 0; s < STAGE_COUNT; s++) begin : g_step
    div_step_stage #(
      .STAGE_COUNT (STAGE_COUNT)
    ) u_step (
      .clk        (clk),
      .rst        (rst),
      .valid_i    (valid_link[s]),
      .rem_i      (rem_link[s]),
      .quo_i      (quo_link[s]),
      .divisor_i  (divisor_link[s]),
      .negate_i   (negate_link[s]),
      .want_rem_i (want_rem_link[s]),
      .valid_o    (valid_link[s+1]),
      .rem_o      (rem_link[s+1]),
      .quo_o      (quo_link[s+1]),
      .divisor_o  (divisor_link[s+1]),
      .negate_o   (negate_link[s+1]),
      .want_rem_o (want_rem_link[s+1])
    );
  end

  // the divisor is no longer needed once the last step has run
  div_result_fix u_fix (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (valid_link[STAGE_COUNT]),
    .rem_i      (rem_link[STAGE_COUNT]),
    .quo_i      (quo_link[STAGE_COUNT]),
    .negate_i   (negate_link[STAGE_COUNT]),
    .want_rem_i (want_rem_link[STAGE_COUNT]),
    .valid_o    (valid_o),
    .result_o   (result_o)
  );

endmodule

//--- source/div_pkg.sv
package div_pkg;

  // operand and result width of the divide unit
  localparam int XLEN = 32;

  // operands, partial remainders and results all share this type
  typedef logic [XLEN-1:0] word_t;

  // divide operations of the RV32M extension
  // encoding follows the low two funct3 bits of the instructions,
  // so bit 0 marks the unsigned forms and bit 1 marks the remainder forms
  typedef enum logic [1:0] {
    DIV_OP_DIV  = 2'b00,
    DIV_OP_DIVU = 2'b01,
    DIV_OP_REM  = 2'b10,
    DIV_OP_REMU = 2'b11
  } div_op_e;

endpackage

//--- source/div_result_fix.sv
`timescale 1ns/1ps

// output stage of the divide pipeline
// picks the quotient or remainder and restores the sign worked out in prep
module div_result_fix import div_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  valid_i,
  input  word_t rem_i,
  input  word_t quo_i,
  input  logic  negate_i,
  input  logic  want_rem_i,
  output logic  valid_o,
  output word_t result_o
);

  word_t selected;
  word_t fixed;

  assign selected = want_rem_i ? rem_i : quo_i;

  // two's complement when the signed result is negative
  assign fixed = negate_i ? (~selected + 1'b1) : selected;

  // result strobe, one cycle per completed operation
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    result_o <= fixed;
  end

endmodule

//--- source/div_step_stage.sv
`timescale 1ns/1ps

// one stage of the restoring divider
// resolves XLEN / STAGE_COUNT quotient bits per cycle
module div_step_stage import div_pkg::*; #(
  parameter int STAGE_COUNT = 8
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  valid_i,
  input  word_t rem_i,
  input  word_t quo_i,
  input  word_t divisor_i,
  input  logic  negate_i,
  input  logic  want_rem_i,
  output logic  valid_o,
  output word_t rem_o,
  output word_t quo_o,
  output word_t divisor_o,
  output logic  negate_o,
  output logic  want_rem_o
);

  localparam int BITS_PER_STAGE = XLEN / STAGE_COUNT;

  word_t rem_next;
  word_t quo_next;

  // quo holds the dividend bits not yet consumed in its upper part and
  // the quotient bits produced so far in its lower part
  always_comb begin
    logic [XLEN:0] shifted;
    logic          q_bit;

    rem_next = rem_i;
    quo_next = quo_i;
    for (int i = 0; i < BITS_PER_STAGE; i++) begin
      // bring down the next dividend bit
      shifted = {rem_next, quo_next[XLEN-1]};
      // one extra bit so the compare never wraps
      q_bit = (shifted >= {1'b0, divisor_i});
      if (q_bit) begin
        shifted = shifted - {1'b0, divisor_i};
      end
      // remainder stays below the divisor, top bit is always clear here
      rem_next = shifted[XLEN-1:0];
      quo_next = {quo_next[XLEN-2:0], q_bit};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload moves on every cycle, whether the slot is occupied or not
  always_ff @(posedge clk) begin
    rem_o      <= rem_next;
    quo_o      <= quo_next;
    divisor_o  <= divisor_i;
    negate_o   <= negate_i;
    want_rem_o <= want_rem_i;
  end

endmodule

//--- testbench/div_checker.sv
`timescale 1ns/1ps

// watches the divide unit ports and compares every result with a model
// all ports are sampled on the falling edge half a cycle away from any change
module div_checker import div_pkg::*; #(
  parameter int STAGE_COUNT = 8
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    issue_valid_i,
  input  div_op_e issue_op_i,
  input  word_t   dividend_i,
  input  word_t   divisor_i,
  input  logic    result_valid_i,
  input  word_t   result_i,
  input  logic    test_done_i,
  input  int      test_num_i,
  input  logic    report_final_i,
  output int      error_count_o,
  output int      match_count_o,
  output int      pending_count_o
);

  localparam int LATENCY = STAGE_COUNT + 2;
  localparam word_t MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  int      cycle = 0;
  int      error_count = 0;
  int      match_count = 0;
  int      pending_count = 0;
  int      test_matches = 0;
  int      test_errors = 0;
  word_t   exp_q[$];
  int      due_q[$];
  div_op_e op_q[$];
  word_t   dividend_q[$];
  word_t   divisor_q[$];

  assign error_count_o   = error_count;
  assign match_count_o   = match_count;
  assign pending_count_o = pending_count;

  // RISC-V M rules for the four divide operations
  function automatic word_t model_result(input div_op_e op, input word_t a, input word_t b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    word_t                  result;
    sa = a;
    sb = b;
    result = '0;
    case (op)
      DIV_OP_DIVU: begin
        if (b == '0) result = '1;
        else result = a / b;
      end
      DIV_OP_REMU: begin
        if (b == '0) result = a;
        else result = a % b;
      end
      DIV_OP_DIV: begin
        // signed division truncates toward zero
        if (b == '0) result = '1;
        else if (a == MOST_NEG && b == '1) result = MOST_NEG;
        else result = word_t'(sa / sb);
      end
      default: begin
        // remainder carries the sign of the dividend
        if (b == '0) result = a;
        else if (a == MOST_NEG && b == '1) result = '0;
        else result = word_t'(sa % sb);
      end
    endcase
    return result;
  endfunction

  function automatic string test_name(input int num);
    case (num)
      0:       return "reset and idle";
      1:       return "unsigned random";
      2:       return "signed random";
      3:       return "corner operands";
      4:       return "back-to-back issue";
      5:       return "random gaps";
      default: return "unnamed";
    endcase
  endfunction

  always @(negedge clk) begin
    cycle++;
    if (rst) begin
      if (result_valid_i !== 1'b0) begin
        $display("cycle %0d: valid_o is not low during reset", cycle);
        error_count++;
        test_errors++;
      end
    end else begin
      if (issue_valid_i) begin
        exp_q.push_back(model_result(issue_op_i, dividend_i, divisor_i));
        due_q.push_back(cycle + LATENCY);
        op_q.push_back(issue_op_i);
        dividend_q.push_back(dividend_i);
        divisor_q.push_back(divisor_i);
      end
      if (result_valid_i) begin
        if (due_q.size() == 0 || due_q[0] != cycle) begin
          $display("cycle %0d: valid_o is high but no result is due", cycle);
          error_count++;
          test_errors++;
        end else begin
          if (result_i !== exp_q[0]) begin
            $display("ERROR result_o = 0x%08h, expected 0x%08h (%s 0x%08h / 0x%08h)",
                     result_i, exp_q[0], op_q[0].name(), dividend_q[0], divisor_q[0]);
            error_count++;
            test_errors++;
          end else begin
            match_count++;
            test_matches++;
          end
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
          void'(op_q.pop_front());
          void'(dividend_q.pop_front());
          void'(divisor_q.pop_front());
        end
      end
      // a due result that did not show up
      if (due_q.size() > 0 && due_q[0] == cycle) begin
        $display("cycle %0d: result of %s issued in cycle %0d never appeared on valid_o",
                 cycle, op_q[0].name(), due_q[0] - LATENCY);
        error_count++;
        test_errors++;
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
        void'(op_q.pop_front());
        void'(dividend_q.pop_front());
        void'(divisor_q.pop_front());
      end
    end
    pending_count = due_q.size();

    if (test_done_i) begin
      $display("test %0d %s: %0d results matched, %0d errors, %s", test_num_i,
               test_name(test_num_i), test_matches, test_errors,
               (test_errors == 0) ? "ok" : "with errors");
      test_matches = 0;
      test_errors = 0;
    end
    if (report_final_i) begin
      $display("summary: %0d results matched, %0d errors, %0d still pending",
               match_count, error_count, pending_count);
    end
  end

endmodule

//--- testbench/tb_div_pipeline.sv
`timescale 1ns/1ps

module tb_div_pipeline import div_pkg::*; ();

  localparam int STAGE_COUNT = 8;
  localparam int LATENCY = STAGE_COUNT + 2;
  localparam int CLK_HALF = 20;
  localparam int RESET_CYCLES = 8;
  localparam logic [31:0] SEED = 32'h9acd;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  localparam int N_UNSIGNED = 200;
  localparam int N_SIGNED = 200;
  localparam int N_CORNER = 16;
  localparam int N_BURST = 64;
  localparam int N_GAPPED = 64;
  localparam int MAX_GAP = 3;
  localparam int NUM_TESTS = 6;
  localparam int MARGIN = 100;
  // each test ends with LATENCY idle cycles plus one report cycle
  localparam int TIMEOUT_CYCLES = N_UNSIGNED + N_SIGNED + N_CORNER + N_BURST
                                + N_GAPPED * (MAX_GAP + 1) + NUM_TESTS * (LATENCY + 1)
                                + RESET_CYCLES + MARGIN;

  logic        clk;
  logic        rst;
  logic        valid_i;
  div_op_e     op_i;
  word_t       dividend_i;
  word_t       divisor_i;
  logic        valid_o;
  word_t       result_o;
  logic        test_done;
  int          test_num;
  logic        report_final;
  int          error_count;
  int          match_count;
  int          pending_count;
  logic [31:0] lfsr;
  int          cycle_count = 0;
  int          issued_count = 0;

  always #(CLK_HALF) clk = ~clk;

  div_pipeline_top #(
    .STAGE_COUNT (STAGE_COUNT)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .valid_o    (valid_o),
    .result_o   (result_o)
  );

  div_checker #(
    .STAGE_COUNT (STAGE_COUNT)
  ) u_checker (
    .clk             (clk),
    .rst             (rst),
    .issue_valid_i   (valid_i),
    .issue_op_i      (op_i),
    .dividend_i      (dividend_i),
    .divisor_i       (divisor_i),
    .result_valid_i  (valid_o),
    .result_i        (result_o),
    .test_done_i     (test_done),
    .test_num_i      (test_num),
    .report_final_i  (report_final),
    .error_count_o   (error_count),
    .match_count_o   (match_count),
    .pending_count_o (pending_count)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // one LFSR step per bit, the bit shifted out is the one taken
  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // half of the values are small magnitudes of either sign
  task automatic rand_signed_word(output word_t value);
    logic [31:0] mode;
    logic [31:0] mag;
    logic [31:0] sign;
    take_bits(1, mode);
    if (mode[0]) begin
      take_bits(8, mag);
      take_bits(1, sign);
      value = sign[0] ? (~mag + 32'd1) : mag;
    end else begin
      take_bits(32, value);
    end
  endtask

  // divisor is shifted down by a random amount to spread its size
  task automatic rand_any_op(output div_op_e op, output word_t a, output word_t b);
    logic [31:0] bits;
    logic [31:0] shift;
    take_bits(2, bits);
    op = div_op_e'(bits[1:0]);
    take_bits(32, a);
    take_bits(32, b);
    take_bits(5, shift);
    b = b >> shift[4:0];
  endtask

  task automatic issue_op(input div_op_e op, input word_t a, input word_t b);
    @(posedge clk);
    #1;
    valid_i = 1'b1;
    op_i = op;
    dividend_i = a;
    divisor_i = b;
    issued_count++;
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(posedge clk);
      #1;
      valid_i = 1'b0;
    end
  endtask

  // drain the pipeline, then let the checker print the test line
  task automatic end_test(input int num);
    idle_cycles(LATENCY);
    test_num = num;
    test_done = 1'b1;
    @(posedge clk);
    #1;
    test_done = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] bits;
    logic [31:0] shift;
    div_op_e     op;
    word_t       a;
    word_t       b;

    clk = 1'b0;
    rst = 1'b1;
    valid_i = 1'b0;
    op_i = DIV_OP_DIV;
    dividend_i = '0;
    divisor_i = '0;
    test_done = 1'b0;
    test_num = 0;
    report_final = 1'b0;
    lfsr = SEED;

    // strobes during reset must be dropped, the last one lands on the final reset edge
    for (int c = 0; c < RESET_CYCLES - 1; c++) begin
      @(posedge clk);
      #1;
      valid_i = (c == 3) || (c == RESET_CYCLES - 2);
      dividend_i = 32'd100;
      divisor_i = 32'd7;
    end
    @(posedge clk);
    #1;
    rst = 1'b0;
    valid_i = 1'b0;
    end_test(0);

    for (int n = 0; n < N_UNSIGNED; n++) begin
      take_bits(1, bits);
      op = bits[0] ? DIV_OP_REMU : DIV_OP_DIVU;
      take_bits(32, a);
      take_bits(32, b);
      take_bits(5, shift);
      b = b >> shift[4:0];
      issue_op(op, a, b);
    end
    end_test(1);

    for (int n = 0; n < N_SIGNED; n++) begin
      take_bits(1, bits);
      op = bits[0] ? DIV_OP_REM : DIV_OP_DIV;
      rand_signed_word(a);
      rand_signed_word(b);
      issue_op(op, a, b);
    end
    end_test(2);

    for (int k = 0; k < 4; k++) begin
      issue_op(div_op_e'(k[1:0]), 32'h1234_5678, 32'h0000_0000);
    end
    for (int k = 0; k < 4; k++) begin
      issue_op(div_op_e'(k[1:0]), 32'h8000_0000, 32'h0000_0000);
    end
    for (int k = 0; k < 4; k++) begin
      issue_op(div_op_e'(k[1:0]), 32'h8000_0000, 32'hffff_ffff);
    end
    for (int k = 0; k < 4; k++) begin
      issue_op(div_op_e'(k[1:0]), 32'hffff_fff9, 32'h0000_0001);
    end
    end_test(3);

    for (int n = 0; n < N_BURST; n++) begin
      rand_any_op(op, a, b);
      issue_op(op, a, b);
    end
    end_test(4);

    for (int n = 0; n < N_GAPPED; n++) begin
      rand_any_op(op, a, b);
      issue_op(op, a, b);
      take_bits(2, bits);
      idle_cycles(bits);
    end
    end_test(5);

    @(posedge clk);
    #1;
    report_final = 1'b1;
    @(posedge clk);
    #1;
    report_final = 1'b0;
    @(posedge clk);
    if (error_count == 0 && pending_count == 0 && match_count == issued_count) begin
      $display("Regression passed");
    end else begin
      $display("%0d of %0d issued operations returned a matching result",
               match_count, issued_count);
      $display("Regression failed");
    end
    $finish;
  end

endmodule
